// File: logic/noc_pkg.sv
package noc_pkg;

   // ########################################################################
   // flit format
   // ########################################################################

   // one flit on every channel
   localparam int flit_width = 32;

   // destination field of a header flit
   // a single bit is enough for two outputs
   localparam int dest_msb = 31;
   localparam int dest_lsb = 31;

   // ########################################################################
   // router size
   // ########################################################################

   // input channels and output channels
   localparam int ports = 2;

   // flits per input FIFO, power of two
   localparam int buffer_depth = 4;

   // ########################################################################
   // route decoder
   // ########################################################################

   // idle expects a header, in_worm follows the latched destination
   typedef enum logic {
      idle,
      in_worm
   } route_state_t;

endpackage

// File: logic/noc_channel_if.sv
`timescale 1ns/100ps

// one flit stream with valid/ready handshake
interface noc_channel_if;

   // payload of the current flit
   logic [noc_pkg::flit_width-1:0] flit;
   // final flit of a worm
   logic last;
   // flit and last are meaningful
   logic valid;
   // receiver takes the flit this cycle
   logic ready;

   // upstream side
   modport sender (
      output flit, last, valid,
      input  ready
   );

   // downstream side
   modport receiver (
      input  flit, last, valid,
      output ready
   );

endinterface

// File: logic/noc_arb_rr.sv
`timescale 1ns/100ps

// combinational round-robin arbiter
// search starts one position after the previous grant and wraps
module noc_arb_rr (
   input  logic [noc_pkg::ports-1:0] req,
   input  logic [noc_pkg::ports-1:0] gnt,
   output logic [noc_pkg::ports-1:0] nxt_gnt
);

   always_comb begin : pick
      int prev_idx;
      int idx;
      logic found;

      // position of the previous one-hot grant
      prev_idx = 0;
      for (int j = 0; j < noc_pkg::ports; j++) begin
         if (gnt[j]) begin
            prev_idx = j;
         end
      end

      // first requester after prev_idx, prev_idx itself comes last
      nxt_gnt = '0;
      found = 1'b0;
      for (int i = 1; i <= noc_pkg::ports; i++) begin
         idx = (prev_idx + i) % noc_pkg::ports;
         if (!found && req[idx]) begin
            nxt_gnt[idx] = 1'b1;
            found = 1'b1;
         end
      end
      // no request leaves nxt_gnt all zero
   end

endmodule

// File: logic/noc_buffer.sv
`timescale 1ns/100ps

// per-input flit FIFO
module noc_buffer (
   input  logic            clk,
   input  logic            rst,
   noc_channel_if.receiver wr,
   noc_channel_if.sender   rd
);

   // storage holds {last, flit}
   logic [noc_pkg::flit_width:0] mem [noc_pkg::buffer_depth];

   // pointers wrap on their own, depth is a power of two
   logic [$clog2(noc_pkg::buffer_depth)-1:0] wr_ptr;
   logic [$clog2(noc_pkg::buffer_depth)-1:0] rd_ptr;
   logic [$clog2(noc_pkg::buffer_depth):0]   count;

   logic full;
   logic do_wr;
   logic do_rd;

   assign full = (count == noc_pkg::buffer_depth);

   // head of queue, valid as soon as one flit is stored
   assign rd.valid = (count != '0);
   assign rd.flit  = mem[rd_ptr][noc_pkg::flit_width-1:0];
   assign rd.last  = mem[rd_ptr][noc_pkg::flit_width];

   // when full, a read in the same cycle frees the slot
   assign wr.ready = !full || rd.ready;

   assign do_wr = wr.valid && wr.ready;
   assign do_rd = rd.valid && rd.ready;

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= {wr.last, wr.flit};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         // occupancy
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: logic/noc_demux.sv
`timescale 1ns/100ps

// route decoder for one input
// header picks the output, rest of the worm follows it
module noc_demux (
   input  logic            clk,
   input  logic            rst,
   noc_channel_if.receiver in,
   noc_channel_if.sender   out0,
   noc_channel_if.sender   out1
);

   noc_pkg::route_state_t state;

   // destination latched from the header
   logic [noc_pkg::dest_msb-noc_pkg::dest_lsb:0] dest_q;
   // output in use this cycle
   logic [noc_pkg::dest_msb-noc_pkg::dest_lsb:0] sel;
   logic xfer;

   // header decoded straight from the flit, body uses the latch
   assign sel = (state == noc_pkg::in_worm) ? dest_q
              : in.flit[noc_pkg::dest_msb:noc_pkg::dest_lsb];

   // payload fans out, valid only to the chosen side
   assign out0.flit  = in.flit;
   assign out0.last  = in.last;
   assign out0.valid = in.valid && (sel == '0);
   assign out1.flit  = in.flit;
   assign out1.last  = in.last;
   assign out1.valid = in.valid && (sel != '0);

   assign in.ready = (sel == '0) ? out0.ready : out1.ready;
   assign xfer = in.valid && in.ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= noc_pkg::idle;
      end else begin
         case (state)
            noc_pkg::idle: begin
               // single-flit worm stays in idle
               if (xfer && !in.last) state <= noc_pkg::in_worm;
            end
            noc_pkg::in_worm: begin
               if (xfer && in.last) state <= noc_pkg::idle;
            end
            default: state <= noc_pkg::idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == noc_pkg::idle && xfer) dest_q <= sel;
   end

endmodule

// File: logic/noc_mux.sv
`timescale 1ns/100ps

// output multiplexer
// arbitrates between two worms, never interleaves them
module noc_mux (
   input  logic            clk,
   input  logic            rst,
   noc_channel_if.receiver in0,
   noc_channel_if.receiver in1,
   noc_channel_if.sender   out
);

   // ########################################################################
   // request and grant
   // ########################################################################

   logic [noc_pkg::ports-1:0] in_valid;
   logic [noc_pkg::ports-1:0] req_masked;
   // arbiter pick for a new worm
   logic [noc_pkg::ports-1:0] select;
   // owner of the current or last worm
   logic [noc_pkg::ports-1:0] grant;
   // input connected this cycle
   logic [noc_pkg::ports-1:0] cur;
   // a worm holds the output
   logic active;
   logic xfer;

   assign in_valid = {in1.valid, in0.valid};

   // new worms only start when the output can take the header
   // so a raised valid never has to change its flit
   assign req_masked = active ? '0 : (in_valid & {noc_pkg::ports{out.ready}});

   noc_arb_rr arb_i (
      .req     (req_masked),
      .gnt     (grant),
      .nxt_gnt (select)
   );

   assign cur = active ? grant : select;

   // ########################################################################
   // data path
   // ########################################################################

   assign out.flit  = cur[1] ? in1.flit : in0.flit;
   assign out.last  = cur[1] ? in1.last : in0.last;
   assign out.valid = |(cur & in_valid);

   // only the connected input sees ready
   assign in0.ready = cur[0] && out.ready;
   assign in1.ready = cur[1] && out.ready;

   assign xfer = out.valid && out.ready;

   // grant stays after the worm for the next round-robin pick
   always_ff @(posedge clk) begin
      if (rst) begin
         active <= 1'b0;
         grant  <= {{(noc_pkg::ports-1){1'b0}}, 1'b1};
      end else if (xfer) begin
         if (!active) grant <= select;
         // header with last set is a whole worm
         active <= !out.last;
      end
   end

endmodule

// File: logic/noc_router.sv
`timescale 1ns/100ps

// two-port wormhole router slice
module noc_router (
   input  logic                                              clk,
   input  logic                                              rst,
   input  logic [noc_pkg::ports-1:0][noc_pkg::flit_width-1:0] in_flit,
   input  logic [noc_pkg::ports-1:0]                         in_last,
   input  logic [noc_pkg::ports-1:0]                         in_valid,
   output logic [noc_pkg::ports-1:0]                         in_ready,
   output logic [noc_pkg::ports-1:0][noc_pkg::flit_width-1:0] out_flit,
   output logic [noc_pkg::ports-1:0]                         out_last,
   output logic [noc_pkg::ports-1:0]                         out_valid,
   input  logic [noc_pkg::ports-1:0]                         out_ready
);

   // top-level ports into and out of the channel bundles
   noc_channel_if in_ch  [noc_pkg::ports] ();
   noc_channel_if out_ch [noc_pkg::ports] ();
   // FIFO to decoder
   noc_channel_if in_buf [noc_pkg::ports] ();
   // decoder p to mux o sits at index p*ports+o
   noc_channel_if route  [noc_pkg::ports*noc_pkg::ports] ();

   for (genvar p = 0; p < noc_pkg::ports; p++) begin : g_in
      assign in_ch[p].flit  = in_flit[p];
      assign in_ch[p].last  = in_last[p];
      assign in_ch[p].valid = in_valid[p];
      assign in_ready[p]    = in_ch[p].ready;

      noc_buffer buffer_i (.clk, .rst, .wr(in_ch[p]), .rd(in_buf[p]));

      noc_demux demux_i (
         .clk,
         .rst,
         .in   (in_buf[p]),
         .out0 (route[p*noc_pkg::ports]),
         .out1 (route[p*noc_pkg::ports+1])
      );
   end

   for (genvar o = 0; o < noc_pkg::ports; o++) begin : g_out
      noc_mux mux_i (
         .clk,
         .rst,
         .in0 (route[o]),
         .in1 (route[noc_pkg::ports+o]),
         .out (out_ch[o])
      );

      assign out_flit[o]     = out_ch[o].flit;
      assign out_last[o]     = out_ch[o].last;
      assign out_valid[o]    = out_ch[o].valid;
      assign out_ch[o].ready = out_ready[o];
   end

endmodule

// File: bench/noc_router_assertions.sv
`timescale 1ns/100ps

// handshake rules on the router's top-level streams
module noc_router_assertions (
   input logic                                              clk,
   input logic                                              rst,
   input logic [noc_pkg::ports-1:0][noc_pkg::flit_width-1:0] in_flit,
   input logic [noc_pkg::ports-1:0]                         in_last,
   input logic [noc_pkg::ports-1:0]                         in_valid,
   input logic [noc_pkg::ports-1:0]                         in_ready,
   input logic [noc_pkg::ports-1:0][noc_pkg::flit_width-1:0] out_flit,
   input logic [noc_pkg::ports-1:0]                         out_last,
   input logic [noc_pkg::ports-1:0]                         out_valid,
   input logic [noc_pkg::ports-1:0]                         out_ready
);

   // ########################################################################
   // stalled flits hold
   // ########################################################################

   for (genvar p = 0; p < noc_pkg::ports; p++) begin : g_port
      // upstream side of input p
      in_hold : assert property (@(posedge clk) disable iff (rst)
         in_valid[p] && !in_ready[p]
            |=> in_valid[p] && $stable(in_flit[p]) && $stable(in_last[p]))
         else $error("input %0d changed or dropped a stalled flit", p);

      // router side of output p
      out_hold : assert property (@(posedge clk) disable iff (rst)
         out_valid[p] && !out_ready[p]
            |=> out_valid[p] && $stable(out_flit[p]) && $stable(out_last[p]))
         else $error("output %0d changed or dropped a stalled flit", p);
   end

   // first edge skipped, state is only reset by it
   reset_quiet : assert property (@(posedge clk) $past(rst) && rst |-> out_valid == '0)
      else $error("output valid raised while reset is held");

endmodule

// File: bench/noc_router_tb.sv
`timescale 1ns/100ps

module noc_router_tb;

   // ########################################################################
   // DUT, clock and bound checks
   // ########################################################################

   logic clk = 1'b0;
   logic rst;
   logic [noc_pkg::ports-1:0][noc_pkg::flit_width-1:0] in_flit;
   logic [noc_pkg::ports-1:0] in_last;
   logic [noc_pkg::ports-1:0] in_valid;
   logic [noc_pkg::ports-1:0] in_ready;
   logic [noc_pkg::ports-1:0][noc_pkg::flit_width-1:0] out_flit;
   logic [noc_pkg::ports-1:0] out_last;
   logic [noc_pkg::ports-1:0] out_valid;
   logic [noc_pkg::ports-1:0] out_ready;

   // 20 ns period
   always #10 clk = ~clk;

   noc_router noc_router_i (.*);

   bind noc_router noc_router_assertions assertions_i (.*);

   // {source, last, flit} per line
   // all ones past the end of the list
   logic [39:0] stim_mem [64];
   // {last, flit} per source in file order
   logic [noc_pkg::flit_width:0] feed_q [noc_pkg::ports][$];
   // expected flits indexed by output then source
   logic [noc_pkg::flit_width:0] exp_q [noc_pkg::ports][noc_pkg::ports][$];
   // source holding each output
   // -1 between worms
   int owner [noc_pkg::ports] = '{default: -1};
   int total_flits = 0;
   int seen_flits = 0;
   int reset_edges = 0;
   logic loaded = 1'b0;
   logic [15:0] lfsr = 16'd41;

   // galois LFSR stepped once per bit
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 16'hb400;
      return b;
   endfunction

   task automatic stop_with_failure();
      $display("Finished with errors");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic value_error(input string test, input logic [32:0] expected,
                              input logic [32:0] actual);
      $display("ERR %s expected %h actual %h", test, expected, actual);
      stop_with_failure();
   endtask

   task automatic fail_with_text(input string what);
      $display("%s", what);
      stop_with_failure();
   endtask

   // ########################################################################
   // stimulus
   // ########################################################################

   initial begin : main
      int src;
      int dest [noc_pkg::ports];
      logic at_head [noc_pkg::ports];
      int sent [noc_pkg::ports];
      logic [noc_pkg::ports-1:0] took;

      rst = 1'b1;
      in_flit = '0;
      in_last = '0;
      in_valid = '0;
      out_ready = '0;
      for (int p = 0; p < noc_pkg::ports; p++) begin
         dest[p] = 0;
         at_head[p] = 1'b1;
         sent[p] = 0;
      end

      // header bit 31 of each worm picks its output queue
      for (int i = 0; i < 64; i++) stim_mem[i] = '1;
      $readmemh("bench/noc_router_input.txt", stim_mem);
      for (int i = 0; i < 64 && stim_mem[i][39:36] != 4'hf; i++) begin
         src = int'(stim_mem[i][39:36]);
         assert (src < noc_pkg::ports)
            else fail_with_text($sformatf("input file line %0d has a bad source port", i));
         feed_q[src].push_back(stim_mem[i][32:0]);
         if (at_head[src]) dest[src] = int'(stim_mem[i][noc_pkg::dest_msb:noc_pkg::dest_lsb]);
         exp_q[dest[src]][src].push_back(stim_mem[i][32:0]);
         at_head[src] = stim_mem[i][32];
         total_flits++;
      end
      loaded = 1'b1;

      repeat (16) @(negedge clk);
      rst = 1'b0;
      // first cycle out of reset stays quiet
      @(posedge clk);
      assert (out_valid == '0) else value_error("reset", '0, 33'(out_valid));
      // empty buffers accept on every input
      assert (in_ready == '1)
         else value_error("reset_ready", 33'({noc_pkg::ports{1'b1}}), 33'(in_ready));

      took = '0;
      while (seen_flits < total_flits) begin
         @(negedge clk);
         for (int s = 0; s < noc_pkg::ports; s++) begin
            if (took[s]) sent[s]++;
            // a raised valid keeps its flit until taken
            if (!in_valid[s] || took[s]) begin
               if (sent[s] < feed_q[s].size() && !lfsr_bit()) begin
                  in_flit[s] = feed_q[s][sent[s]][noc_pkg::flit_width-1:0];
                  in_last[s] = feed_q[s][sent[s]][noc_pkg::flit_width];
                  in_valid[s] = 1'b1;
               end else begin
                  in_valid[s] = 1'b0;
               end
            end
         end
         // random back-pressure
         for (int o = 0; o < noc_pkg::ports; o++) out_ready[o] = lfsr_bit();
         @(posedge clk);
         took = in_valid & in_ready;
      end

      // stray flits after the last one hit an empty queue
      @(negedge clk);
      in_valid = '0;
      out_ready = '1;
      repeat (8) @(posedge clk);

      $display("Finished with no errors");
      $finish;
   end

   // ########################################################################
   // output checking
   // ########################################################################

   always @(posedge clk) begin : monitor
      int n;
      int hits;
      logic [32:0] got;

      n = 0;
      if (rst) begin
         // nothing is reset before the first edge
         if (reset_edges > 0) begin
            assert (out_valid == '0) else value_error("reset", '0, 33'(out_valid));
         end
         reset_edges++;
      end else begin
         for (int o = 0; o < noc_pkg::ports; o++) begin
            if (out_valid[o] && out_ready[o]) begin
               got = {out_last[o], out_flit[o]};
               n++;
               if (owner[o] < 0) begin
                  // a header picks the source whose next worm it starts
                  assert (out_flit[o][noc_pkg::dest_msb] == 1'(o))
                     else value_error("routing", 33'(o), 33'(out_flit[o][noc_pkg::dest_msb]));
                  hits = 0;
                  for (int s = 0; s < noc_pkg::ports; s++) begin
                     if (exp_q[o][s].size() > 0 && exp_q[o][s][0] == got) begin
                        hits++;
                        owner[o] = s;
                     end
                  end
                  assert (hits == 1) else fail_with_text($sformatf(
                     "output %0d header %h starts no expected worm", o, out_flit[o]));
               end else begin
                  assert (exp_q[o][owner[o]].size() > 0) else fail_with_text($sformatf(
                     "output %0d sent a flit past the worms of source %0d", o, owner[o]));
                  assert (exp_q[o][owner[o]][0] == got)
                     else value_error("worm_integrity", exp_q[o][owner[o]][0], got);
               end
               void'(exp_q[o][owner[o]].pop_front());
               if (out_last[o]) owner[o] = -1;
            end
         end
      end
      seen_flits <= seen_flits + n;
   end

   initial begin : watchdog
      wait (loaded);
      // reset time plus 40 cycles per flit
      #((16 + 40 * total_flits) * 20);
      $display("timeout: the router did not deliver every flit in time");
      stop_with_failure();
   end

endmodule

// File: bench/noc_router_input.txt
// columns: source port _ last flag _ flit, all hex
// flit digits: destination (8 = output 1), source, worm, 000, flit index
0_0_80010000
0_0_80010001
0_0_80010002
0_0_80010003
0_1_80010004
0_1_00020000
0_0_80030000
0_1_80030001
0_0_00040000
0_1_00040001
1_0_81110000
1_0_81110001
1_0_81110002
1_1_81110003
1_1_81120000
1_0_01130000
1_0_01130001
1_1_01130002
1_0_81140000
1_1_81140001

// File: noc_router.f
logic/noc_pkg.sv
logic/noc_channel_if.sv
logic/noc_arb_rr.sv
logic/noc_buffer.sv
logic/noc_demux.sv
logic/noc_mux.sv
logic/noc_router.sv
bench/noc_router_assertions.sv
bench/noc_router_tb.sv

// File: Makefile
# Verilator build and run of the router testbench

VERILATOR ?= verilator
TOP       ?= noc_router_tb
FILELIST  ?= noc_router.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
DATA      ?= bench/noc_router_input.txt

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM) $(DATA)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
